//--- logic/memoryLoad_defs.svh
`ifndef MEMORY_LOAD_DEFS_SVH
`define MEMORY_LOAD_DEFS_SVH

// ----------------------------------------------------------------------
// Bus and word sizes
// ----------------------------------------------------------------------

// Wishbone data and address width
`define BUS_WIDTH 32

// One X, Y or Z word
`define WORD_WIDTH 32

// ----------------------------------------------------------------------
// Memory depths and address tags
// ----------------------------------------------------------------------

// 256 rows of data
`define DATA_ADDRESS_WIDTH 8

// 256 two-word instructions
`define INSTRUCTION_ADDRESS_WIDTH 8

// Tag codes carried on the bus next to the address
`define TAG_INSTRUCTION 2'b10
`define TAG_DATA 2'b01

`endif

//--- logic/memoryLoadPkg.sv
`include "memoryLoad_defs.svh"

package memoryLoadPkg;

	// ------------------------------------------------------------------
	// Payloads stored in the two memories
	// ------------------------------------------------------------------

	// One data row holds a full vector
	// X sits in the top bits
	typedef struct packed {
		logic [`WORD_WIDTH-1:0] x;
		logic [`WORD_WIDTH-1:0] y;
		logic [`WORD_WIDTH-1:0] z;
	} dataRow_t;

	// Instructions take only the first two words of a bus cycle
	typedef struct packed {
		logic [`WORD_WIDTH-1:0] x;
		logic [`WORD_WIDTH-1:0] y;
	} instruction_t;

	// ------------------------------------------------------------------
	// Address tag
	// ------------------------------------------------------------------

	// Selects which memory a bus cycle is aimed at
	// Any code not listed here commits nothing
	typedef enum logic [1:0] {
		// Write a three-word row into data memory
		tagData        = `TAG_DATA,
		// Write X and Y into instruction memory
		tagInstruction = `TAG_INSTRUCTION,
		// No target
		tagNone        = 2'b00
	} addressTag_t;

endpackage

//--- logic/wishboneLoader.sv
`timescale 1ns/1ps
`include "memoryLoad_defs.svh"

module wishboneLoader import memoryLoadPkg::*; (
	input  logic                              clock,
	input  logic                              reset,
	// Host bus
	input  logic                              cycle,
	input  logic                              strobe,
	input  logic                              writeEnable,
	input  logic                              hostMode,
	input  logic [`BUS_WIDTH-1:0]             address,
	input  logic [`BUS_WIDTH-1:0]             dataIn,
	input  addressTag_t                       addressTag,
	output logic                              ack,
	// Memory write side
	output logic [`DATA_ADDRESS_WIDTH-1:0]    writeAddress,
	output dataRow_t                          dataRow,
	output instruction_t                      instructionWord,
	output logic                              dataWrite,
	output logic                              instructionWrite
);

	// ------------------------------------------------------------------
	// Cycle edge detection
	// ------------------------------------------------------------------

	// Previous value of cycle
	logic cycleDelay;
	// First clock with cycle high
	logic cycleStart;
	// First clock with cycle low again
	logic cycleEnd;

	always_ff @(posedge clock) begin
		if (reset) begin
			cycleDelay <= 1'b0;
		end else begin
			cycleDelay <= cycle;
		end
	end

	assign cycleStart = cycle & ~cycleDelay;
	assign cycleEnd   = ~cycle & cycleDelay;

	// ------------------------------------------------------------------
	// Address and tag capture
	// ------------------------------------------------------------------

	addressTag_t capturedTag;

	// Target memory latched at cycle start
	always_ff @(posedge clock) begin
		if (reset) begin
			capturedTag <= tagNone;
		end else if (cycleStart) begin
			capturedTag <= addressTag;
		end
	end

	// Row address only needs the low bits of the bus address
	always_ff @(posedge clock) begin
		if (cycleStart) begin
			writeAddress <= address[`DATA_ADDRESS_WIDTH-1:0];
		end
	end

	// ------------------------------------------------------------------
	// Acknowledge
	// ------------------------------------------------------------------

	// A write beat is on the bus
	logic beatOffered;
	// Beat offered one clock earlier
	logic ackDelay;
	// First clock of a beat, before ack rises
	logic beatTake;

	assign beatOffered = cycle & strobe & writeEnable;

	always_ff @(posedge clock) begin
		if (reset) begin
			ackDelay <= 1'b0;
		end else begin
			ackDelay <= beatOffered;
		end
	end

	// Ack drops together with strobe
	assign ack = ackDelay & strobe;

	// Word is latched once per beat
	assign beatTake = beatOffered & ~ack;

	// ------------------------------------------------------------------
	// Word slots
	// ------------------------------------------------------------------

	// One-hot X/Y/Z pointer
	// Bit 0 is X, bit 2 is Z, all zero after Z
	logic [2:0] slotSelect;
	logic [`WORD_WIDTH-1:0] wordX;
	logic [`WORD_WIDTH-1:0] wordY;
	logic [`WORD_WIDTH-1:0] wordZ;

	// Parked on X while the bus is idle
	// so every cycle starts at X
	always_ff @(posedge clock) begin
		if (reset || !cycle) begin
			slotSelect <= 3'b001;
		end else if (beatTake) begin
			slotSelect <= {slotSelect[1:0], 1'b0};
		end
	end

	// Slots hold across cycles
	// A short cycle reuses older words
	always_ff @(posedge clock) begin
		if (reset) begin
			wordX <= '0;
			wordY <= '0;
			wordZ <= '0;
		end else if (beatTake) begin
			if (slotSelect[0]) begin
				wordX <= dataIn[`WORD_WIDTH-1:0];
			end
			if (slotSelect[1]) begin
				wordY <= dataIn[`WORD_WIDTH-1:0];
			end
			if (slotSelect[2]) begin
				wordZ <= dataIn[`WORD_WIDTH-1:0];
			end
		end
	end

	// Both payloads slice the same slots
	assign dataRow         = {wordX, wordY, wordZ};
	assign instructionWord = {wordX, wordY};

	// ------------------------------------------------------------------
	// Commit
	// ------------------------------------------------------------------

	// Only in host mode
	logic commit;

	assign commit = cycleEnd & hostMode;

	// One-clock pulse in the clock after cycle is seen low
	always_ff @(posedge clock) begin
		if (reset) begin
			dataWrite        <= 1'b0;
			instructionWrite <= 1'b0;
		end else begin
			dataWrite        <= commit && (capturedTag == tagData);
			instructionWrite <= commit && (capturedTag == tagInstruction);
		end
	end

endmodule

//--- logic/rowMemory.sv
`timescale 1ns/1ps

module rowMemory #(
	// Data row or instruction entry type
	parameter type payload_t = logic [31:0],
	// Depth is two to this power
	parameter int addressWidth = 8
) (
	input  logic                    clock,
	// Write port
	input  logic                    write,
	input  logic [addressWidth-1:0] writeAddress,
	input  payload_t                writeData,
	// Read port
	input  logic [addressWidth-1:0] readAddress,
	output payload_t                readData
);

	// ------------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------------

	localparam int depth = 1 << addressWidth;

	payload_t memory [0:depth-1];

	// ------------------------------------------------------------------
	// Write port
	// ------------------------------------------------------------------

	// Whole entry written in one clock
	always_ff @(posedge clock) begin
		if (write) begin
			memory[writeAddress] <= writeData;
		end
	end

	// ------------------------------------------------------------------
	// Read port
	// ------------------------------------------------------------------

	// Registered output
	// data for an address appears one clock later
	always_ff @(posedge clock) begin
		readData <= memory[readAddress];
	end

endmodule

//--- logic/memoryLoadTop.sv
`timescale 1ns/1ps
`include "memoryLoad_defs.svh"

module memoryLoadTop import memoryLoadPkg::*; (
	input  logic                                   clock,
	input  logic                                   reset,
	// Host bus
	input  logic                                   cycle,
	input  logic                                   strobe,
	input  logic                                   writeEnable,
	input  logic [`BUS_WIDTH-1:0]                  address,
	input  addressTag_t                            addressTag,
	input  logic [`BUS_WIDTH-1:0]                  dataIn,
	input  logic                                   hostMode,
	output logic                                   ack,
	// Read-back ports
	input  logic [`DATA_ADDRESS_WIDTH-1:0]         dataReadAddress,
	input  logic [`INSTRUCTION_ADDRESS_WIDTH-1:0]  instructionReadAddress,
	output dataRow_t                               dataReadRow,
	output instruction_t                           instructionReadWord
);

	// ------------------------------------------------------------------
	// Loader to memory wiring
	// ------------------------------------------------------------------

	logic [`DATA_ADDRESS_WIDTH-1:0] writeAddress;
	dataRow_t                       dataRow;
	instruction_t                   instructionWord;
	logic                           dataWrite;
	logic                           instructionWrite;

	// Bus slave
	wishboneLoader u_loader (
		.clock            (clock),
		.reset            (reset),
		.cycle            (cycle),
		.strobe           (strobe),
		.writeEnable      (writeEnable),
		.hostMode         (hostMode),
		.address          (address),
		.dataIn           (dataIn),
		.addressTag       (addressTag),
		.ack              (ack),
		.writeAddress     (writeAddress),
		.dataRow          (dataRow),
		.instructionWord  (instructionWord),
		.dataWrite        (dataWrite),
		.instructionWrite (instructionWrite)
	);

	// ------------------------------------------------------------------
	// Memories
	// ------------------------------------------------------------------

	// Three-word rows
	rowMemory #(
		.payload_t    (dataRow_t),
		.addressWidth (`DATA_ADDRESS_WIDTH)
	) u_dataMemory (
		.clock        (clock),
		.write        (dataWrite),
		.writeAddress (writeAddress),
		.writeData    (dataRow),
		.readAddress  (dataReadAddress),
		.readData     (dataReadRow)
	);

	// Two-word instructions
	// shares the captured address with the data side
	rowMemory #(
		.payload_t    (instruction_t),
		.addressWidth (`INSTRUCTION_ADDRESS_WIDTH)
	) u_instructionMemory (
		.clock        (clock),
		.write        (instructionWrite),
		.writeAddress (writeAddress[`INSTRUCTION_ADDRESS_WIDTH-1:0]),
		.writeData    (instructionWord),
		.readAddress  (instructionReadAddress),
		.readData     (instructionReadWord)
	);

endmodule

//--- testbench/memoryLoadTb.sv
`timescale 1ns/1ps
`include "memoryLoad_defs.svh"

module memoryLoadTb import memoryLoadPkg::*; ();

	// ------------------------------------------------------------------
	// Run limits and table layout
	// ------------------------------------------------------------------

	localparam int tableLength = 14;
	// About 40 clocks per bus cycle plus reset margin
	localparam int cycleLimit = tableLength * 40 + 200;
	localparam int depth = 1 << `DATA_ADDRESS_WIDTH;

	// Memory expected to take the cycle
	localparam logic [1:0] targetNone = 2'd0;
	localparam logic [1:0] targetData = 2'd1;
	localparam logic [1:0] targetInstruction = 2'd2;

	typedef struct {
		addressTag_t                    tag;
		logic                           hostMode;
		logic [`DATA_ADDRESS_WIDTH-1:0] address;
		int                             beats;
		logic [1:0]                     target;
	} tableEntry_t;

	// DUT inputs
	logic clock;
	logic reset;
	logic cycle;
	logic strobe;
	logic writeEnable;
	logic [`BUS_WIDTH-1:0] address;
	addressTag_t addressTag;
	logic [`BUS_WIDTH-1:0] dataIn;
	logic hostMode;
	logic [`DATA_ADDRESS_WIDTH-1:0] dataReadAddress;
	logic [`INSTRUCTION_ADDRESS_WIDTH-1:0] instructionReadAddress;
	// DUT outputs
	logic ack;
	dataRow_t dataReadRow;
	instruction_t instructionReadWord;

	// Reference model of slots and both memories
	logic [`WORD_WIDTH-1:0] slotX;
	logic [`WORD_WIDTH-1:0] slotY;
	logic [`WORD_WIDTH-1:0] slotZ;
	dataRow_t dataModel [depth];
	bit dataKnown [depth];
	instruction_t instructionModel [depth];
	bit instructionKnown [depth];

	tableEntry_t entries [tableLength];
	integer seed = 32'h7a92;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int index;

	memoryLoadTop u_dut (
		.clock                  (clock),
		.reset                  (reset),
		.cycle                  (cycle),
		.strobe                 (strobe),
		.writeEnable            (writeEnable),
		.address                (address),
		.addressTag             (addressTag),
		.dataIn                 (dataIn),
		.hostMode               (hostMode),
		.ack                    (ack),
		.dataReadAddress        (dataReadAddress),
		.instructionReadAddress (instructionReadAddress),
		.dataReadRow            (dataReadRow),
		.instructionReadWord    (instructionReadWord)
	);

	// 40 ns clock
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Hard stop if the bus never settles
	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------

	task automatic checkValue(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error: %s expected %h got %h at %0t", name, expected, actual, $time);
		end
	endtask

	// Columns are tag, host mode, address, beats and the memory that must change
	task automatic loadTable();
		entries[0]  = '{tagData,        1'b1, 8'h10, 3, targetData};
		entries[1]  = '{tagInstruction, 1'b1, 8'h10, 2, targetInstruction};
		entries[2]  = '{tagData,        1'b1, 8'h20, 3, targetData};
		entries[3]  = '{tagInstruction, 1'b1, 8'h20, 2, targetInstruction};
		// No tag, then host mode off
		entries[4]  = '{tagNone,        1'b1, 8'h10, 3, targetNone};
		entries[5]  = '{tagData,        1'b0, 8'h20, 3, targetNone};
		entries[6]  = '{tagInstruction, 1'b0, 8'h10, 2, targetNone};
		// Short cycles reuse old Y and Z
		entries[7]  = '{tagData,        1'b1, 8'h10, 1, targetData};
		// Beats past Z are dropped
		entries[8]  = '{tagData,        1'b1, 8'h20, 5, targetData};
		entries[9]  = '{tagInstruction, 1'b1, 8'h20, 1, targetInstruction};
		entries[10] = '{tagData,        1'b1, 8'h30, 3, targetData};
		entries[11] = '{tagInstruction, 1'b1, 8'h30, 3, targetInstruction};
		entries[12] = '{tagNone,        1'b0, 8'h30, 2, targetNone};
		entries[13] = '{tagData,        1'b1, 8'hff, 4, targetData};
	endtask

	// One write beat with a random idle gap before it
	task automatic driveBeat(input logic [`BUS_WIDTH-1:0] word);
		int gap;
		int latency;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(posedge clock);
		@(posedge clock);
		strobe <= 1'b1;
		dataIn <= word;
		// Wait for ack within a bounded number of clocks
		latency = 0;
		@(negedge clock);
		while (!ack && latency < 8) begin
			latency++;
			@(negedge clock);
		end
		// Ack one clock after the beat is offered
		checkValue("ack latency", 128'(1), 128'(latency));
		@(posedge clock);
		strobe <= 1'b0;
		@(negedge clock);
		// Ack drops with strobe
		checkValue("ack", 128'(1'b0), 128'(ack));
	endtask

	// Full bus cycle, model update and read-back
	task automatic runEntry(input tableEntry_t entry);
		logic [`BUS_WIDTH-1:0] word;
		int beat;
		@(posedge clock);
		cycle <= 1'b1;
		writeEnable <= 1'b1;
		address <= {{(`BUS_WIDTH-`DATA_ADDRESS_WIDTH){1'b0}}, entry.address};
		addressTag <= entry.tag;
		hostMode <= entry.hostMode;
		dataReadAddress <= entry.address;
		instructionReadAddress <= entry.address;
		for (beat = 0; beat < entry.beats; beat++) begin
			word = $random(seed);
			driveBeat(word);
			// Slots fill X, Y, Z in order
			if (beat == 0) begin
				slotX = word;
			end else if (beat == 1) begin
				slotY = word;
			end else if (beat == 2) begin
				slotZ = word;
			end
		end
		@(posedge clock);
		cycle <= 1'b0;
		writeEnable <= 1'b0;
		if (entry.target == targetData) begin
			dataModel[entry.address] = {slotX, slotY, slotZ};
			dataKnown[entry.address] = 1'b1;
		end else if (entry.target == targetInstruction) begin
			instructionModel[entry.address] = {slotX, slotY};
			instructionKnown[entry.address] = 1'b1;
		end
		// Pulse, write, then registered read
		repeat (4) @(posedge clock);
		@(negedge clock);
		// Locations never written hold no known value
		if (dataKnown[entry.address]) begin
			checkValue("dataReadRow", 128'(dataModel[entry.address]), 128'(dataReadRow));
		end
		if (instructionKnown[entry.address]) begin
			checkValue("instructionReadWord", 128'(instructionModel[entry.address]),
				128'(instructionReadWord));
		end
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------

	initial begin
		reset = 1'b1;
		cycle = 1'b0;
		strobe = 1'b0;
		writeEnable = 1'b0;
		address = '0;
		addressTag = tagNone;
		dataIn = '0;
		hostMode = 1'b0;
		dataReadAddress = '0;
		instructionReadAddress = '0;
		// Slots come out of reset at zero
		slotX = '0;
		slotY = '0;
		slotZ = '0;
		loadTable();
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkValue("ack", 128'(1'b0), 128'(ack));
		for (index = 0; index < tableLength; index++) begin
			runEntry(entries[index]);
		end
		repeat (2) @(posedge clock);
		$display("Checks: %0d  Errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+logic
logic/memoryLoadPkg.sv
logic/wishboneLoader.sv
logic/rowMemory.sv
logic/memoryLoadTop.sv
testbench/memoryLoadTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the memory load testbench with Verilator.
# Exits nonzero when any step fails or the pass line is missing.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_NAME=memoryLoadSim
LOG_FILE=sim.log

echo "Compiling with Verilator"
verilator --binary --timing --timescale 1ns/1ps \
	-f tb.f \
	--top-module memoryLoadTb \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_NAME"
status=$?
if [ $status -ne 0 ]; then
	echo "Compile failed with status $status"
	exit 1
fi

echo "Running simulation"
"./$BUILD_DIR/$SIM_NAME" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" "$LOG_FILE"; then
	echo "Test passed"
	exit 0
else
	echo "Test failed, see $LOG_FILE"
	exit 1
fi
